// File: verilog/tetris_params.svh
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// playfield geometry
// row 0 is the top of the field, row 21 the bottom
`define TETRIS_ROWS 22

// bit 9 is the leftmost column, bit 0 the rightmost
`define TETRIS_COLS 10

// spawn columns
// leftmost column of the three-wide spawn shapes
`define TETRIS_SPAWN_COL 5

// the line is four wide, so it starts one column further left
`define TETRIS_LINE_COL 6

`endif

// File: verilog/tetris_grid_pkg.sv
`include "tetris_params.svh"

package tetris_grid_pkg;

    // one playfield row
    // bit 9 is the leftmost column
    typedef logic [`TETRIS_COLS-1:0] row_t;

    // full playfield, indexed by row number
    // index 0 is the top row
    // a set bit marks an occupied cell
    typedef row_t [`TETRIS_ROWS-1:0] grid_t;

endpackage

// File: verilog/tetris_piece_pkg.sv
package tetris_piece_pkg;

    // piece types in spawn order
    typedef enum logic [2:0] {
        // four in a row
        LINE      = 3'd0,
        // two by two square
        SMASHBOY  = 3'd1,
        // hook up on the right
        L         = 3'd2,
        // hook up on the left
        REVERSE_L = 3'd3,
        S         = 3'd4,
        Z         = 3'd5,
        // bump in the middle
        T         = 3'd6
    } piece_t;

    // length of the rotation order
    parameter int PIECE_COUNT = 7;

    // next type in the rotation
    // wraps from the last type back to LINE
    function automatic piece_t next_piece(input piece_t cur);
        if (int'(cur) >= PIECE_COUNT - 1) begin
            return LINE;
        end
        return piece_t'(cur + 3'd1);
    endfunction

endpackage

// File: verilog/key_sync.sv
`timescale 1ns/1ps

module key_sync (
    input  logic clk,
    input  logic reset,
    input  logic button,
    output logic press
);

    // two-stage synchronizer
    logic sync_q1;
    logic sync_q2;
    // previous synchronized level for edge detect
    logic sync_prev;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            sync_prev <= 1'b0;
            press     <= 1'b0;
        end else begin
            sync_q1   <= button;
            sync_q2   <= sync_q1;
            sync_prev <= sync_q2;
            // rising edge only, so a held button fires once
            press     <= sync_q2 & ~sync_prev;
        end
    end

endmodule

// File: verilog/piece_picker.sv
`timescale 1ns/1ps

module piece_picker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      spawn,
    output tetris_piece_pkg::piece_t  piece_type
);

    // current type, stepped once per spawn cycle
    // new_game does not touch this, the rotation keeps going
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece_type <= tetris_piece_pkg::LINE;
        end else if (spawn) begin
            piece_type <= tetris_piece_pkg::next_piece(piece_type);
        end
    end

endmodule

// File: verilog/piece_spawner.sv
`timescale 1ns/1ps

`include "tetris_params.svh"

module piece_spawner (
    input  tetris_piece_pkg::piece_t  piece_type,
    output tetris_grid_pkg::grid_t    spawn_grid
);

    // columns of the three-wide shapes, left to right
    localparam int C0 = `TETRIS_SPAWN_COL;
    localparam int C1 = `TETRIS_SPAWN_COL - 1;
    localparam int C2 = `TETRIS_SPAWN_COL - 2;

    always_comb begin
        spawn_grid = '0;
        // shapes only ever touch rows 0 and 1
        case (piece_type)
            tetris_piece_pkg::LINE: begin
                // flat in row 1, one column wider on the left
                for (int c = `TETRIS_LINE_COL - 3; c <= `TETRIS_LINE_COL; c++) begin
                    spawn_grid[1][c] = 1'b1;
                end
            end
            tetris_piece_pkg::SMASHBOY: begin
                spawn_grid[0][C0] = 1'b1;
                spawn_grid[0][C1] = 1'b1;
                spawn_grid[1][C0] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
            end
            tetris_piece_pkg::L: begin
                spawn_grid[0][C2] = 1'b1;
                spawn_grid[1][C0] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
                spawn_grid[1][C2] = 1'b1;
            end
            tetris_piece_pkg::REVERSE_L: begin
                spawn_grid[0][C0] = 1'b1;
                spawn_grid[1][C0] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
                spawn_grid[1][C2] = 1'b1;
            end
            tetris_piece_pkg::S: begin
                // upper pair sits one column right of the lower pair
                spawn_grid[0][C1] = 1'b1;
                spawn_grid[0][C2] = 1'b1;
                spawn_grid[1][C0] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
            end
            tetris_piece_pkg::Z: begin
                spawn_grid[0][C0] = 1'b1;
                spawn_grid[0][C1] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
                spawn_grid[1][C2] = 1'b1;
            end
            tetris_piece_pkg::T: begin
                spawn_grid[0][C1] = 1'b1;
                spawn_grid[1][C0] = 1'b1;
                spawn_grid[1][C1] = 1'b1;
                spawn_grid[1][C2] = 1'b1;
            end
            // unused encoding spawns nothing
            default: spawn_grid = '0;
        endcase
    end

endmodule

// File: verilog/piece_mover.sv
`timescale 1ns/1ps

`include "tetris_params.svh"

module piece_mover (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spawn,
    input  logic                    falling,
    input  logic                    merge,
    input  logic                    tick,
    input  logic                    left_press,
    input  logic                    right_press,
    input  tetris_grid_pkg::grid_t  spawn_grid,
    input  tetris_grid_pkg::grid_t  stored_grid,
    output tetris_grid_pkg::grid_t  active_grid,
    output logic                    land
);

    // candidate positions after each kind of move
    tetris_grid_pkg::grid_t down_grid;
    tetris_grid_pkg::grid_t left_grid;
    tetris_grid_pkg::grid_t right_grid;

    // piece already touches a side wall
    logic left_wall;
    logic right_wall;

    logic down_blocked;
    logic left_blocked;
    logic right_blocked;

    // one row down the field
    // nothing enters at the top
    always_comb begin
        down_grid[0] = '0;
        for (int r = 1; r < `TETRIS_ROWS; r++) begin
            down_grid[r] = active_grid[r-1];
        end
    end

    // sideways shifts and wall hits, row by row
    always_comb begin
        left_wall  = 1'b0;
        right_wall = 1'b0;
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            // toward bit 9
            left_grid[r]  = active_grid[r] << 1;
            // toward bit 0
            right_grid[r] = active_grid[r] >> 1;
            left_wall     = left_wall | active_grid[r][`TETRIS_COLS-1];
            right_wall    = right_wall | active_grid[r][0];
        end
    end

    // blocked by the floor or by the stack
    assign down_blocked = (|active_grid[`TETRIS_ROWS-1]) ||
                          (|(down_grid & stored_grid));

    // blocked by a wall or by the stack
    assign left_blocked  = left_wall || (|(left_grid & stored_grid));
    assign right_blocked = right_wall || (|(right_grid & stored_grid));

    // tick with no legal move down means the piece has landed
    assign land = falling && tick && down_blocked;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            active_grid <= '0;
        end else if (spawn) begin
            // fresh piece at the top
            // a failing spawn is hidden by the display mask in GAMEOVER
            active_grid <= spawn_grid;
        end else if (merge) begin
            // piece now lives in the stack
            active_grid <= '0;
        end else if (falling) begin
            // gravity first, presses in a tick cycle are dropped
            if (tick) begin
                if (!down_blocked) begin
                    active_grid <= down_grid;
                end
            end else if (left_press) begin
                if (!left_blocked) begin
                    active_grid <= left_grid;
                end
            end else if (right_press) begin
                if (!right_blocked) begin
                    active_grid <= right_grid;
                end
            end
        end
    end

endmodule

// File: verilog/tetris_controller.sv
`timescale 1ns/1ps

module tetris_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    new_game,
    input  logic                    land,
    input  tetris_grid_pkg::grid_t  spawn_grid,
    input  tetris_grid_pkg::grid_t  active_grid,
    output logic                    spawn,
    output logic                    falling,
    output logic                    merge,
    output tetris_grid_pkg::grid_t  stored_grid,
    output tetris_grid_pkg::grid_t  display,
    output logic                    landed,
    output logic                    game_over
);

    // game FSM states
    typedef enum logic [1:0] {
        SPAWN    = 2'd0,
        FALLING  = 2'd1,
        LANDED   = 2'd2,
        GAMEOVER = 2'd3
    } game_state_t;

    game_state_t state;
    game_state_t state_next;

    // new piece collides with the stack at spawn time
    logic spawn_overlap;

    assign spawn_overlap = |(spawn_grid & stored_grid);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= SPAWN;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // single cycle, picker and mover act on it
            SPAWN:    state_next = spawn_overlap ? GAMEOVER : FALLING;
            // wait for a blocked tick from the mover
            FALLING:  state_next = land ? LANDED : FALLING;
            // merge cycle, then the next piece
            LANDED:   state_next = SPAWN;
            // frozen until a restart
            GAMEOVER: state_next = new_game ? SPAWN : GAMEOVER;
            default:  state_next = SPAWN;
        endcase
    end

    // stored stack
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored_grid <= '0;
        end else if (state == LANDED) begin
            stored_grid <= stored_grid | active_grid;
        end else if (state == GAMEOVER && new_game) begin
            // restart with an empty field
            stored_grid <= '0;
        end
    end

    // state decodes
    assign spawn     = (state == SPAWN);
    assign falling   = (state == FALLING);
    assign merge     = (state == LANDED);
    assign landed    = merge;
    assign game_over = (state == GAMEOVER);

    // display composition
    // active piece only shows while it is falling
    always_comb begin
        if (falling) begin
            display = stored_grid | active_grid;
        end else begin
            display = stored_grid;
        end
    end

endmodule

// File: verilog/tetris_top.sv
`timescale 1ns/1ps

module tetris_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      new_game,
    input  logic                      left_button,
    input  logic                      right_button,
    output tetris_grid_pkg::grid_t    display,
    output tetris_piece_pkg::piece_t  piece_type,
    output logic                      landed,
    output logic                      game_over
);

    // button strobes
    logic left_press;
    logic right_press;

    // controller decodes
    logic spawn;
    logic falling;
    logic merge;

    // mover result
    logic land;

    tetris_grid_pkg::grid_t spawn_grid;
    tetris_grid_pkg::grid_t active_grid;
    tetris_grid_pkg::grid_t stored_grid;

    key_sync i_left_sync (
        .clk    (clk),
        .reset  (reset),
        .button (left_button),
        .press  (left_press)
    );

    key_sync i_right_sync (
        .clk    (clk),
        .reset  (reset),
        .button (right_button),
        .press  (right_press)
    );

    piece_picker i_piece_picker (
        .clk        (clk),
        .reset      (reset),
        .spawn      (spawn),
        .piece_type (piece_type)
    );

    piece_spawner i_piece_spawner (
        .piece_type (piece_type),
        .spawn_grid (spawn_grid)
    );

    piece_mover i_piece_mover (
        .clk         (clk),
        .reset       (reset),
        .spawn       (spawn),
        .falling     (falling),
        .merge       (merge),
        .tick        (tick),
        .left_press  (left_press),
        .right_press (right_press),
        .spawn_grid  (spawn_grid),
        .stored_grid (stored_grid),
        .active_grid (active_grid),
        .land        (land)
    );

    tetris_controller i_controller (
        .clk         (clk),
        .reset       (reset),
        .new_game    (new_game),
        .land        (land),
        .spawn_grid  (spawn_grid),
        .active_grid (active_grid),
        .spawn       (spawn),
        .falling     (falling),
        .merge       (merge),
        .stored_grid (stored_grid),
        .display     (display),
        .landed      (landed),
        .game_over   (game_over)
    );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: dv/tetris_tb.sv
`timescale 1ns/1ps

`include "tetris_params.svh"

module tetris_tb;

    localparam int CLK_PERIOD_NS = 100;
    localparam int MAX_PIECES = 40;
    // worst case clk cycles per stimulus event
    localparam int EVENT_CYCLES = 12;
    // pieces x 30 ticks x cycles per tick x period, twice over
    localparam longint WATCHDOG_NS =
        longint'(MAX_PIECES) * 30 * EVENT_CYCLES * CLK_PERIOD_NS * 2;

    logic clk;
    logic reset;
    logic tick;
    logic new_game;
    logic left_button;
    logic right_button;
    tetris_grid_pkg::grid_t display;
    tetris_piece_pkg::piece_t piece_type;
    logic landed;
    logic game_over;

    // reference model of the field
    tetris_grid_pkg::grid_t m_stored;
    tetris_grid_pkg::grid_t m_active;
    // active piece visible on the display
    logic m_showing;
    logic [2:0] m_piece;
    logic m_landed;
    logic m_over;

    logic [31:0] lfsr;
    int value_errors;
    int other_errors;
    int pieces;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock (.clk(clk));

    tetris_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .new_game     (new_game),
        .left_button  (left_button),
        .right_button (right_button),
        .display      (display),
        .piece_type   (piece_type),
        .landed       (landed),
        .game_over    (game_over)
    );

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // spawn shapes, rows 0 and 1, column bits from the table
    function automatic tetris_grid_pkg::grid_t shape_of(input logic [2:0] p);
        tetris_grid_pkg::grid_t g;
        g = '0;
        case (p)
            3'd0: g[1] = 10'h078;
            3'd1: begin
                g[0] = 10'h030;
                g[1] = 10'h030;
            end
            3'd2: begin
                g[0] = 10'h008;
                g[1] = 10'h038;
            end
            3'd3: begin
                g[0] = 10'h020;
                g[1] = 10'h038;
            end
            3'd4: begin
                g[0] = 10'h018;
                g[1] = 10'h030;
            end
            3'd5: begin
                g[0] = 10'h030;
                g[1] = 10'h018;
            end
            3'd6: begin
                g[0] = 10'h010;
                g[1] = 10'h038;
            end
            default: g = '0;
        endcase
        return g;
    endfunction

    // cell by cell move, dc > 0 goes right toward bit 0
    // returns 0 if a cell leaves the field or hits the stack
    function automatic logic try_move(input tetris_grid_pkg::grid_t g, input int dr,
                                      input int dc, output tetris_grid_pkg::grid_t moved);
        int nr;
        int nc;
        logic ok;
        moved = '0;
        ok = 1'b1;
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            for (int c = 0; c < `TETRIS_COLS; c++) begin
                if (g[r][c]) begin
                    nr = r + dr;
                    nc = c - dc;
                    if (nr >= `TETRIS_ROWS || nc < 0 || nc >= `TETRIS_COLS) begin
                        ok = 1'b0;
                    end else if (m_stored[nr][nc]) begin
                        ok = 1'b0;
                    end else begin
                        moved[nr][nc] = 1'b1;
                    end
                end
            end
        end
        return ok;
    endfunction

    // drive point, shortly after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #10;
    endtask

    task automatic check_outputs;
        tetris_grid_pkg::grid_t exp_display;
        exp_display = m_showing ? (m_stored | m_active) : m_stored;
        assert (display === exp_display) else begin
            value_errors++;
            $display("FAIL display: expected %h, got %h", exp_display, display);
        end
        assert (piece_type === m_piece) else begin
            value_errors++;
            $display("FAIL piece_type: expected %h, got %h", m_piece, piece_type);
        end
        assert (landed === m_landed) else begin
            value_errors++;
            $display("FAIL landed: expected %h, got %h", m_landed, landed);
        end
        assert (game_over === m_over) else begin
            value_errors++;
            $display("FAIL game_over: expected %h, got %h", m_over, game_over);
        end
    endtask

    // one gravity strobe, piece drops or lands
    task automatic apply_tick;
        tetris_grid_pkg::grid_t moved;
        tick = 1'b1;
        next_cycle();
        tick = 1'b0;
        if (!m_over) begin
            if (try_move(m_active, 1, 0, moved)) begin
                m_active = moved;
            end else begin
                m_landed = 1'b1;
                m_showing = 1'b0;
            end
        end
        check_outputs();
    endtask

    // held 5 cycles, quiet 5 cycles, strobe lands in between
    task automatic press_button(input logic go_left);
        tetris_grid_pkg::grid_t moved;
        if (go_left) begin
            left_button = 1'b1;
        end else begin
            right_button = 1'b1;
        end
        repeat (5) next_cycle();
        left_button = 1'b0;
        right_button = 1'b0;
        repeat (5) next_cycle();
        if (!m_over && try_move(m_active, 0, go_left ? -1 : 1, moved)) begin
            m_active = moved;
        end
        check_outputs();
    endtask

    // SPAWN cycle, then either falling or game over
    task automatic spawn_piece;
        logic overlap;
        overlap = |(shape_of(m_piece) & m_stored);
        next_cycle();
        m_active = shape_of(m_piece);
        m_piece = (m_piece == 3'd6) ? 3'd0 : m_piece + 3'd1;
        m_over = overlap;
        m_showing = !overlap;
        check_outputs();
    endtask

    // merge at the end of LANDED, SPAWN cycle follows
    task automatic finish_landing;
        next_cycle();
        m_stored = m_stored | m_active;
        m_active = '0;
        m_landed = 1'b0;
        check_outputs();
        spawn_piece();
    endtask

    task automatic drop_piece;
        int n;
        n = 0;
        while (!m_landed && n < `TETRIS_ROWS + 2) begin
            apply_tick();
            n++;
        end
        pieces++;
        if (!m_landed) begin
            other_errors++;
            $display("piece %0d never landed after %0d ticks", pieces, n);
        end else begin
            finish_landing();
        end
    endtask

    // ticks until the next one would land the piece
    task automatic lower_piece;
        tetris_grid_pkg::grid_t moved;
        int n;
        n = 0;
        while (try_move(m_active, 1, 0, moved) && n < `TETRIS_ROWS) begin
            apply_tick();
            n++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int lefts;
        int rights;
        reset = 1'b1;
        tick = 1'b0;
        new_game = 1'b0;
        left_button = 1'b0;
        right_button = 1'b0;
        lfsr = 32'h5909;
        value_errors = 0;
        other_errors = 0;
        pieces = 0;
        m_stored = '0;
        m_active = '0;
        m_showing = 1'b0;
        m_piece = 3'd0;
        m_landed = 1'b0;
        m_over = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        // first cycle out of reset is SPAWN with LINE
        check_outputs();
        spawn_piece();

        // first two pieces run into the walls, then random shifts
        for (int i = 0; i < 9 && !m_over; i++) begin
            if (i < 2) begin
                lefts = (i == 0) ? 7 : 0;
                rights = (i == 1) ? 7 : 0;
            end else begin
                random_bits(2, lefts);
                random_bits(2, rights);
            end
            repeat (lefts) press_button(1'b1);
            repeat (rights) press_button(1'b0);
            drop_piece();
        end

        // straight drops until a spawn hits the stack
        while (!m_over && pieces < MAX_PIECES) begin
            drop_piece();
        end
        if (!m_over) begin
            other_errors++;
            $display("stack never reached the spawn rows, no game over seen");
        end

        // display frozen during game over
        apply_tick();
        press_button(1'b1);
        apply_tick();

        // restart on an empty field, rotation carries on
        new_game = 1'b1;
        next_cycle();
        new_game = 1'b0;
        m_stored = '0;
        m_over = 1'b0;
        check_outputs();
        spawn_piece();

        // first piece parked against the left wall on the floor
        repeat (7) press_button(1'b1);
        drop_piece();
        // next piece lowered beside it and pushed into the stack
        lower_piece();
        repeat (4) press_button(1'b1);
        drop_piece();

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/tetris_grid_pkg.sv
verilog/tetris_piece_pkg.sv
verilog/key_sync.sv
verilog/piece_picker.sv
verilog/piece_spawner.sv
verilog/piece_mover.sv
verilog/tetris_controller.sv
verilog/tetris_top.sv
dv/tb_clock.sv
dv/tetris_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tetris_tb -f list.f -o tetris_sim \
    && ./obj_dir/tetris_sim | tee sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
